// File: Bender.yml
package:
  name: dec_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dec_pkg.sv
      - rtl/gpr_read_if.sv
      - rtl/instr_decoder.sv
      - rtl/imm_gen.sv
      - rtl/gpr_file.sv
      - rtl/operand_bypass.sv
      - rtl/dec_ex_reg.sv
      - rtl/dec_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/dec_tb.sv

// File: project.f
+incdir+rtl
rtl/dec_pkg.sv
rtl/gpr_read_if.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/gpr_file.sv
rtl/operand_bypass.sv
rtl/dec_ex_reg.sv
rtl/dec_stage.sv
tb/dec_tb.sv

// File: rtl/dec_consts.svh
/*
 decode stage constants
 widths, RV32IM opcodes and funct codes, and the no-destination index
*/
`ifndef DEC_CONSTS_SVH
`define DEC_CONSTS_SVH

`define DATA_WIDTH     32
`define ADDR_WIDTH     32
`define INSTR_WIDTH    32
`define REG_IDX_WIDTH  5
`define RD_EXT_WIDTH   6
`define NO_RD          6'd32	// outside the 5-bit index range, never matches a source

// major opcodes
`define OP_LUI         7'b0110111
`define OP_AUIPC       7'b0010111
`define OP_JAL         7'b1101111
`define OP_JALR        7'b1100111
`define OP_BRANCH      7'b1100011
`define OP_LOAD        7'b0000011
`define OP_STORE       7'b0100011
`define OP_ALU_IR      7'b0010011
`define OP_ALU_RR      7'b0110011

`define FUNCT7_BASE    7'b0000000
`define FUNCT7_ALT     7'b0100000	// sub and sra
`define FUNCT7_MULDIV  7'b0000001

// alu group
`define F3_ADD         3'b000
`define F3_SLL         3'b001
`define F3_SLT         3'b010
`define F3_SLTU        3'b011
`define F3_XOR         3'b100
`define F3_SRL         3'b101
`define F3_OR          3'b110
`define F3_AND         3'b111

// branch group
`define F3_BEQ         3'b000
`define F3_BNE         3'b001
`define F3_BLT         3'b100
`define F3_BGE         3'b101
`define F3_BLTU        3'b110
`define F3_BGEU        3'b111

// load/store group, bit 2 marks unsigned loads
`define F3_LSB         3'b000
`define F3_LSH         3'b001
`define F3_LSW         3'b010
`define F3_LBU         3'b100
`define F3_LHU         3'b101

`define PC_STEP        32'd4

`endif

// File: rtl/dec_ex_reg.sv
/*
 DEC to EX pipeline register
 loads on ex_ready, holds otherwise, and idles itself on redirect or its own jalr
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module dec_ex_reg (
	input  logic                     cpu_clk,
	input  logic                     cpu_rstn,
	input  logic                     if_valid,
	input  logic                     ex_ready,
	input  logic                     redirect_ex,
	input  dec_pkg::ex_ctrl_t        ctrl,
	input  logic [`DATA_WIDTH-1:0]   src1,
	input  logic [`DATA_WIDTH-1:0]   src2,
	input  logic [`DATA_WIDTH-1:0]   store_data,
	input  logic [`DATA_WIDTH-1:0]   imm,
	input  logic [`ADDR_WIDTH-1:0]   pc,
	output logic                     dec_valid,
	output dec_pkg::alu_op_e         alu_op_ex,
	output dec_pkg::br_op_e          br_op_ex,
	output logic                     load_ex,
	output logic                     store_ex,
	output dec_pkg::mem_size_e       mem_size_ex,
	output logic                     mem_unsigned_ex,
	output logic                     jalr_ex,
	output logic                     only_src2_ex,
	output logic [`DATA_WIDTH-1:0]   src1_ex,
	output logic [`DATA_WIDTH-1:0]   src2_ex,
	output logic [`DATA_WIDTH-1:0]   store_data_ex,
	output logic [`DATA_WIDTH-1:0]   imm_ex,
	output logic [`RD_EXT_WIDTH-1:0] rd_ex,
	output logic [`ADDR_WIDTH-1:0]   pc_ex
);
	import dec_pkg::*;

	logic flush;

	assign flush = redirect_ex || jalr_ex;	// jalr target resolves in EX

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dec_valid <= 1'b0;
			alu_op_ex <= ALU_NONE;
			br_op_ex <= BR_NONE;
			load_ex <= 1'b0;
			store_ex <= 1'b0;
			mem_size_ex <= MEM_B;
			mem_unsigned_ex <= 1'b0;
			jalr_ex <= 1'b0;
			only_src2_ex <= 1'b0;
			src1_ex <= '0;
			src2_ex <= '0;
			store_data_ex <= '0;
			imm_ex <= '0;
			rd_ex <= `NO_RD;
			pc_ex <= '0;
		end
		else if (ex_ready)
		begin
			if (flush)
			begin
				dec_valid <= 1'b0;
				alu_op_ex <= ALU_NONE;
				br_op_ex <= BR_NONE;
				load_ex <= 1'b0;
				store_ex <= 1'b0;
				mem_size_ex <= MEM_B;
				mem_unsigned_ex <= 1'b0;
				jalr_ex <= 1'b0;
				only_src2_ex <= 1'b0;
				src1_ex <= '0;
				src2_ex <= '0;
				store_data_ex <= '0;
				imm_ex <= '0;
				rd_ex <= `NO_RD;	// pc_ex keeps the last pc
			end
			else
			begin
				dec_valid <= if_valid;
				alu_op_ex <= ctrl.alu_op;
				br_op_ex <= ctrl.br_op;
				load_ex <= ctrl.load;
				store_ex <= ctrl.store;
				mem_size_ex <= ctrl.mem_size;
				mem_unsigned_ex <= ctrl.mem_unsigned;
				jalr_ex <= ctrl.jalr;
				only_src2_ex <= ctrl.only_src2;
				src1_ex <= src1;
				src2_ex <= src2;
				store_data_ex <= store_data;
				imm_ex <= imm;
				rd_ex <= ctrl.rd;	// already NO_RD when not valid
				pc_ex <= pc;
			end
		end
	end

endmodule

// File: rtl/dec_pkg.sv
/*
 decode stage types
 operation encodings and the control bundle handed to EX
*/
`include "dec_consts.svh"

package dec_pkg;

	typedef enum logic [4:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,	// M ops follow funct3 order from here
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU,
		ALU_DIV,
		ALU_DIVU,
		ALU_REM,
		ALU_REMU
	} alu_op_e;

	typedef enum logic [2:0] {BR_NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU} br_op_e;

	typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W} mem_size_e;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U, IMM_NONE} imm_fmt_e;

	typedef struct packed {
		alu_op_e                  alu_op;
		br_op_e                   br_op;
		logic                     load;
		logic                     store;
		mem_size_e                mem_size;
		logic                     mem_unsigned;
		logic                     jal;
		logic                     jalr;
		logic                     src1_pc;	// auipc
		logic                     src1_zero;	// lui, jal
		logic                     src2_link;	// pc + 4
		logic                     src2_imm;
		logic                     only_src2;	// lui, jal, jalr
		logic [`RD_EXT_WIDTH-1:0] rd;
	} ex_ctrl_t;

endpackage

// File: rtl/dec_stage.sv
/*
 decode stage of the RV32IM pipeline
 decode, register read, forwarding and the DEC to EX register
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module dec_stage (
	input  logic                      cpu_clk,
	input  logic                      cpu_rstn,
	input  logic                      if_valid,
	input  logic [`INSTR_WIDTH-1:0]   instr,
	input  logic [`ADDR_WIDTH-1:0]    pc,
	input  logic                      ex_ready,
	input  logic                      redirect_ex,	// taken branch or exception in EX
	input  logic [`DATA_WIDTH-1:0]    alu_result_ex,
	input  logic [`RD_EXT_WIDTH-1:0]  mem_rd,
	input  logic [`DATA_WIDTH-1:0]    mem_data,
	input  logic                      wb_valid,
	input  logic [`REG_IDX_WIDTH-1:0] wb_rd,
	input  logic [`DATA_WIDTH-1:0]    wb_data,
	output logic                      dec_ready,
	output logic                      jal_dec,
	output logic [`DATA_WIDTH-1:0]    imm_dec,
	output logic                      dec_valid,
	output dec_pkg::alu_op_e          alu_op_ex,
	output dec_pkg::br_op_e           br_op_ex,
	output logic                      load_ex,
	output logic                      store_ex,
	output dec_pkg::mem_size_e        mem_size_ex,
	output logic                      mem_unsigned_ex,
	output logic                      jalr_ex,
	output logic                      only_src2_ex,
	output logic [`DATA_WIDTH-1:0]    src1_ex,
	output logic [`DATA_WIDTH-1:0]    src2_ex,
	output logic [`DATA_WIDTH-1:0]    store_data_ex,
	output logic [`DATA_WIDTH-1:0]    imm_ex,
	output logic [`RD_EXT_WIDTH-1:0]  rd_ex,
	output logic [`ADDR_WIDTH-1:0]    pc_ex
);
	import dec_pkg::*;

	ex_ctrl_t                  ctrl_dec;
	imm_fmt_e                  imm_fmt;
	logic [`REG_IDX_WIDTH-1:0] rs1;
	logic [`REG_IDX_WIDTH-1:0] rs2;
	logic [`DATA_WIDTH-1:0]    src1;
	logic [`DATA_WIDTH-1:0]    src2;
	logic [`DATA_WIDTH-1:0]    store_data;

	gpr_read_if rd_bus ();

	assign dec_ready = ex_ready;	// no stall sources of its own
	assign jal_dec = ctrl_dec.jal;	// fetch redirects early on jal

	instr_decoder instr_decoder_inst (
		.instr    (instr),
		.if_valid (if_valid),
		.ctrl     (ctrl_dec),
		.imm_fmt  (imm_fmt),
		.rs1      (rs1),
		.rs2      (rs2)
	);

	imm_gen imm_gen_inst (
		.instr   (instr),
		.imm_fmt (imm_fmt),
		.imm     (imm_dec)
	);

	gpr_file gpr_file_inst (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.rd_port  (rd_bus)
	);

	operand_bypass operand_bypass_inst (
		.ctrl          (ctrl_dec),
		.rs1           (rs1),
		.rs2           (rs2),
		.imm           (imm_dec),
		.pc            (pc),
		.rd_ex         (rd_ex),
		.alu_result_ex (alu_result_ex),
		.mem_rd        (mem_rd),
		.mem_data      (mem_data),
		.wb_valid      (wb_valid),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.rd_port       (rd_bus),
		.src1          (src1),
		.src2          (src2),
		.store_data    (store_data)
	);

	dec_ex_reg dec_ex_reg_inst (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.if_valid        (if_valid),
		.ex_ready        (ex_ready),
		.redirect_ex     (redirect_ex),
		.ctrl            (ctrl_dec),
		.src1            (src1),
		.src2            (src2),
		.store_data      (store_data),
		.imm             (imm_dec),
		.pc              (pc),
		.dec_valid       (dec_valid),
		.alu_op_ex       (alu_op_ex),
		.br_op_ex        (br_op_ex),
		.load_ex         (load_ex),
		.store_ex        (store_ex),
		.mem_size_ex     (mem_size_ex),
		.mem_unsigned_ex (mem_unsigned_ex),
		.jalr_ex         (jalr_ex),
		.only_src2_ex    (only_src2_ex),
		.src1_ex         (src1_ex),
		.src2_ex         (src2_ex),
		.store_data_ex   (store_data_ex),
		.imm_ex          (imm_ex),
		.rd_ex           (rd_ex),
		.pc_ex           (pc_ex)
	);

endmodule

// File: rtl/gpr_file.sv
/*
 general purpose register file
 31 writable words with x0 tied to zero, two combinational reads, one write
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module gpr_file (
	input  logic                      cpu_clk,
	input  logic                      cpu_rstn,
	input  logic                      wb_valid,
	input  logic [`REG_IDX_WIDTH-1:0] wb_rd,
	input  logic [`DATA_WIDTH-1:0]    wb_data,
	gpr_read_if.file                  rd_port
);

	logic [`DATA_WIDTH-1:0] regs [1:31];	// no storage behind x0

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_valid && (wb_rd != '0))
		begin
			regs[wb_rd] <= wb_data;
		end
	end

	// same-cycle write-back is picked up by the bypass, not here
	assign rd_port.data1 = (rd_port.rs1 == '0) ? '0 : regs[rd_port.rs1];
	assign rd_port.data2 = (rd_port.rs2 == '0) ? '0 : regs[rd_port.rs2];

endmodule

// File: rtl/gpr_read_if.sv
/*
 register file read bus
 two source indices out, two data words back in the same cycle
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

interface gpr_read_if;
	logic [`REG_IDX_WIDTH-1:0] rs1;
	logic [`REG_IDX_WIDTH-1:0] rs2;
	logic [`DATA_WIDTH-1:0]    data1;
	logic [`DATA_WIDTH-1:0]    data2;

	modport requester (
		output rs1, rs2,
		input  data1, data2
	);

	modport file (
		input  rs1, rs2,
		output data1, data2
	);
endinterface

// File: rtl/imm_gen.sv
/*
 immediate generator
 sign-extends the I, S, B and J fields, places the U field in the top 20 bits
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module imm_gen (
	input  logic [`INSTR_WIDTH-1:0] instr,
	input  dec_pkg::imm_fmt_e       imm_fmt,
	output logic [`DATA_WIDTH-1:0]  imm
);
	import dec_pkg::*;

	logic sign;

	assign sign = instr[31];	// rv32 keeps the sign bit in one place for every format

	always_comb
	begin
		case (imm_fmt)
			IMM_I:
				imm = {{20{sign}}, instr[31:20]};
			IMM_S:
				imm = {{20{sign}}, instr[31:25], instr[11:7]};
			IMM_B:
				imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			IMM_J:
				imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			IMM_U:
				imm = {instr[31:12], 12'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

// File: rtl/instr_decoder.sv
/*
 instruction decoder
 splits the fields and classifies opcode, funct3 and funct7 into EX controls
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module instr_decoder (
	input  logic [`INSTR_WIDTH-1:0]   instr,
	input  logic                      if_valid,
	output dec_pkg::ex_ctrl_t         ctrl,
	output dec_pkg::imm_fmt_e         imm_fmt,
	output logic [`REG_IDX_WIDTH-1:0] rs1,
	output logic [`REG_IDX_WIDTH-1:0] rs2
);
	import dec_pkg::*;

	logic [6:0]                opcode;
	logic [6:0]                funct7;
	logic [2:0]                funct3;
	logic [`REG_IDX_WIDTH-1:0] rd;
	alu_op_e                   alu_op_f3;	// base integer op from funct3 alone
	logic                      write_rd;

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	always_comb
	begin
		case (funct3)
			`F3_ADD:  alu_op_f3 = ALU_ADD;
			`F3_SLL:  alu_op_f3 = ALU_SLL;
			`F3_SLT:  alu_op_f3 = ALU_SLT;
			`F3_SLTU: alu_op_f3 = ALU_SLTU;
			`F3_XOR:  alu_op_f3 = ALU_XOR;
			`F3_SRL:  alu_op_f3 = ALU_SRL;
			`F3_OR:   alu_op_f3 = ALU_OR;
			default:  alu_op_f3 = ALU_AND;
		endcase
	end

	always_comb
	begin
		ctrl = '0;	// idle unless a legal class below claims it
		ctrl.rd = `NO_RD;
		imm_fmt = IMM_NONE;
		write_rd = 1'b0;
		if (if_valid)
		begin
			case (opcode)
				`OP_LUI:
				begin
					ctrl.src1_zero = 1'b1;
					ctrl.src2_imm = 1'b1;
					ctrl.only_src2 = 1'b1;
					imm_fmt = IMM_U;
					write_rd = 1'b1;
				end
				`OP_AUIPC:
				begin
					ctrl.alu_op = ALU_ADD;
					ctrl.src1_pc = 1'b1;
					ctrl.src2_imm = 1'b1;
					imm_fmt = IMM_U;
					write_rd = 1'b1;
				end
				`OP_JAL:
				begin
					ctrl.jal = 1'b1;
					ctrl.src1_zero = 1'b1;
					ctrl.src2_link = 1'b1;
					ctrl.only_src2 = 1'b1;
					imm_fmt = IMM_J;
					write_rd = 1'b1;
				end
				`OP_JALR:
				begin
					if (funct3 == 3'b000)
					begin
						ctrl.jalr = 1'b1;
						ctrl.src2_link = 1'b1;
						ctrl.only_src2 = 1'b1;
						imm_fmt = IMM_I;
						write_rd = 1'b1;
					end
				end
				`OP_BRANCH:
				begin
					case (funct3)
						`F3_BEQ:  ctrl.br_op = BEQ;
						`F3_BNE:  ctrl.br_op = BNE;
						`F3_BLT:  ctrl.br_op = BLT;
						`F3_BGE:  ctrl.br_op = BGE;
						`F3_BLTU: ctrl.br_op = BLTU;
						`F3_BGEU: ctrl.br_op = BGEU;
						default:  ctrl.br_op = BR_NONE;
					endcase
					case (ctrl.br_op)
						BEQ, BNE:   ctrl.alu_op = ALU_SUB;	// equality from the difference
						BLT, BGE:   ctrl.alu_op = ALU_SLT;
						BLTU, BGEU: ctrl.alu_op = ALU_SLTU;
						default:    ctrl.alu_op = ALU_NONE;
					endcase
					if (ctrl.br_op != BR_NONE)
						imm_fmt = IMM_B;
				end
				`OP_LOAD:
				begin
					if (funct3 inside {`F3_LSB, `F3_LSH, `F3_LSW, `F3_LBU, `F3_LHU})
					begin
						ctrl.load = 1'b1;
						ctrl.alu_op = ALU_ADD;	// address = rs1 + imm
						ctrl.mem_size = mem_size_e'(funct3[1:0]);
						ctrl.mem_unsigned = funct3[2];
						ctrl.src2_imm = 1'b1;
						imm_fmt = IMM_I;
						write_rd = 1'b1;
					end
				end
				`OP_STORE:
				begin
					if (funct3 inside {`F3_LSB, `F3_LSH, `F3_LSW})
					begin
						ctrl.store = 1'b1;
						ctrl.alu_op = ALU_ADD;
						ctrl.mem_size = mem_size_e'(funct3[1:0]);
						ctrl.src2_imm = 1'b1;
						imm_fmt = IMM_S;
					end
				end
				`OP_ALU_IR:
				begin
					if (funct3 == `F3_SLL)
						ctrl.alu_op = (funct7 == `FUNCT7_BASE) ? ALU_SLL : ALU_NONE;
					else if (funct3 == `F3_SRL)
						ctrl.alu_op = (funct7 == `FUNCT7_BASE) ? ALU_SRL :
							(funct7 == `FUNCT7_ALT) ? ALU_SRA : ALU_NONE;
					else
						ctrl.alu_op = alu_op_f3;	// funct7 bits belong to the immediate
					if (ctrl.alu_op != ALU_NONE)
					begin
						ctrl.src2_imm = 1'b1;
						imm_fmt = IMM_I;
						write_rd = 1'b1;
					end
				end
				`OP_ALU_RR:
				begin
					case (funct7)
						`FUNCT7_BASE:   ctrl.alu_op = alu_op_f3;
						`FUNCT7_ALT:    ctrl.alu_op = (funct3 == `F3_ADD) ? ALU_SUB :
							(funct3 == `F3_SRL) ? ALU_SRA : ALU_NONE;
						`FUNCT7_MULDIV: ctrl.alu_op = alu_op_e'(ALU_MUL + 5'(funct3));
						default:        ctrl.alu_op = ALU_NONE;
					endcase
					write_rd = (ctrl.alu_op != ALU_NONE);
				end
				default:
				begin
					ctrl.alu_op = ALU_NONE;	// unknown opcode stays idle
				end
			endcase
		end
		if (write_rd)
			ctrl.rd = {1'b0, rd};
	end

endmodule

// File: rtl/operand_bypass.sv
/*
 operand bypass
 forwards EX, MEM and WB results over the file read and selects the ALU operands
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module operand_bypass (
	input  dec_pkg::ex_ctrl_t         ctrl,
	input  logic [`REG_IDX_WIDTH-1:0] rs1,
	input  logic [`REG_IDX_WIDTH-1:0] rs2,
	input  logic [`DATA_WIDTH-1:0]    imm,
	input  logic [`ADDR_WIDTH-1:0]    pc,
	input  logic [`RD_EXT_WIDTH-1:0]  rd_ex,
	input  logic [`DATA_WIDTH-1:0]    alu_result_ex,
	input  logic [`RD_EXT_WIDTH-1:0]  mem_rd,
	input  logic [`DATA_WIDTH-1:0]    mem_data,
	input  logic                      wb_valid,
	input  logic [`REG_IDX_WIDTH-1:0] wb_rd,
	input  logic [`DATA_WIDTH-1:0]    wb_data,
	gpr_read_if.requester             rd_port,
	output logic [`DATA_WIDTH-1:0]    src1,
	output logic [`DATA_WIDTH-1:0]    src2,
	output logic [`DATA_WIDTH-1:0]    store_data
);
	import dec_pkg::*;

	logic [`DATA_WIDTH-1:0] rs1_val;
	logic [`DATA_WIDTH-1:0] rs2_val;

	// newest producer wins: ex, then mem, then wb, then the file
	function automatic logic [`DATA_WIDTH-1:0] fwd_src(
		input logic [`REG_IDX_WIDTH-1:0] idx,
		input logic [`DATA_WIDTH-1:0]    file_data
	);
		logic [`RD_EXT_WIDTH-1:0] idx_ext;
		idx_ext = {1'b0, idx};
		if (idx == '0)
			return '0;
		else if (idx_ext == rd_ex)
			return alu_result_ex;
		else if (idx_ext == mem_rd)
			return mem_data;
		else if (wb_valid && (idx == wb_rd))
			return wb_data;
		else
			return file_data;
	endfunction

	assign rd_port.rs1 = rs1;
	assign rd_port.rs2 = rs2;

	always_comb
	begin
		rs1_val = fwd_src(rs1, rd_port.data1);
		rs2_val = fwd_src(rs2, rd_port.data2);
	end

	always_comb
	begin
		if (ctrl.src1_pc)
			src1 = pc;
		else if (ctrl.src1_zero)
			src1 = '0;
		else
			src1 = rs1_val;
	end

	always_comb
	begin
		if (ctrl.src2_link)
			src2 = pc + `PC_STEP;	// link address for jal/jalr
		else if (ctrl.src2_imm)
			src2 = imm;
		else if (ctrl.alu_op != ALU_NONE)
			src2 = rs2_val;	// R and B formats
		else
			src2 = '0;
	end

	assign store_data = rs2_val;

endmodule

// File: tb/dec_tb.sv
/*
 decode stage testbench
 random RV32IM traffic checked against a reference model with its own register array
*/
`timescale 1ns/10ps
`include "dec_consts.svh"

module dec_tb;
	import dec_pkg::*;

	localparam int NUM_CYCLES = 3000;
	localparam int CLK_PERIOD = 100;
	// operand source codes of the model
	localparam logic [1:0] S1_REG = 2'd0;
	localparam logic [1:0] S1_PC = 2'd1;
	localparam logic [1:0] S1_ZERO = 2'd2;
	localparam logic [1:0] S2_ZERO = 2'd0;
	localparam logic [1:0] S2_LINK = 2'd1;
	localparam logic [1:0] S2_IMM = 2'd2;
	localparam logic [1:0] S2_REG = 2'd3;

	logic                      cpu_clk;
	logic                      cpu_rstn;
	logic                      if_valid, ex_ready, redirect_ex, wb_valid;
	logic [`INSTR_WIDTH-1:0]   instr;
	logic [`ADDR_WIDTH-1:0]    pc;
	logic [`DATA_WIDTH-1:0]    alu_result_ex, mem_data, wb_data;
	logic [`RD_EXT_WIDTH-1:0]  mem_rd;
	logic [`REG_IDX_WIDTH-1:0] wb_rd;
	logic                      dec_ready, jal_dec, dec_valid;
	logic [`DATA_WIDTH-1:0]    imm_dec, src1_ex, src2_ex, store_data_ex, imm_ex;
	alu_op_e                   alu_op_ex;
	br_op_e                    br_op_ex;
	mem_size_e                 mem_size_ex;
	logic                      load_ex, store_ex, mem_unsigned_ex, jalr_ex, only_src2_ex;
	logic [`RD_EXT_WIDTH-1:0]  rd_ex;
	logic [`ADDR_WIDTH-1:0]    pc_ex;

	// model state mirroring the DEC to EX register
	logic [`DATA_WIDTH-1:0]    model_regs [0:31];
	logic                      m_valid, m_load, m_store, m_uns, m_jalr, m_only2;
	alu_op_e                   m_alu;
	br_op_e                    m_br;
	mem_size_e                 m_size;
	logic [`DATA_WIDTH-1:0]    m_src1, m_src2, m_sdata, m_imm;
	logic [`RD_EXT_WIDTH-1:0]  m_rd;
	logic [`ADDR_WIDTH-1:0]    m_pc;

	// decode of the instruction currently offered
	alu_op_e                   d_alu;
	br_op_e                    d_br;
	mem_size_e                 d_size;
	imm_fmt_e                  d_fmt;
	logic                      d_load, d_store, d_uns, d_jal, d_jalr, d_only2, d_wr;
	logic [1:0]                d_s1sel, d_s2sel;

	int checks;
	int errors;

	dec_stage dec_stage_inst (
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.if_valid        (if_valid),
		.instr           (instr),
		.pc              (pc),
		.ex_ready        (ex_ready),
		.redirect_ex     (redirect_ex),
		.alu_result_ex   (alu_result_ex),
		.mem_rd          (mem_rd),
		.mem_data        (mem_data),
		.wb_valid        (wb_valid),
		.wb_rd           (wb_rd),
		.wb_data         (wb_data),
		.dec_ready       (dec_ready),
		.jal_dec         (jal_dec),
		.imm_dec         (imm_dec),
		.dec_valid       (dec_valid),
		.alu_op_ex       (alu_op_ex),
		.br_op_ex        (br_op_ex),
		.load_ex         (load_ex),
		.store_ex        (store_ex),
		.mem_size_ex     (mem_size_ex),
		.mem_unsigned_ex (mem_unsigned_ex),
		.jalr_ex         (jalr_ex),
		.only_src2_ex    (only_src2_ex),
		.src1_ex         (src1_ex),
		.src2_ex         (src2_ex),
		.store_data_ex   (store_data_ex),
		.imm_ex          (imm_ex),
		.rd_ex           (rd_ex),
		.pc_ex           (pc_ex)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic muldiv);
		case (f3)
			3'd0: return muldiv ? ALU_MUL : ALU_ADD;
			3'd1: return muldiv ? ALU_MULH : ALU_SLL;
			3'd2: return muldiv ? ALU_MULHSU : ALU_SLT;
			3'd3: return muldiv ? ALU_MULHU : ALU_SLTU;
			3'd4: return muldiv ? ALU_DIV : ALU_XOR;
			3'd5: return muldiv ? ALU_DIVU : ALU_SRL;
			3'd6: return muldiv ? ALU_REM : ALU_OR;
			default: return muldiv ? ALU_REMU : ALU_AND;
		endcase
	endfunction

	// sign fill shifted up from bit 31, field bits or'ed in below it
	function automatic logic [31:0] imm_value(input imm_fmt_e fmt, input logic [31:0] ins);
		case (fmt)
			IMM_I: return ({32{ins[31]}} << 12) | ins[31:20];
			IMM_S: return ({32{ins[31]}} << 12) | (ins[31:25] << 5) | ins[11:7];
			IMM_B: return ({32{ins[31]}} << 12) | (ins[7] << 11) | (ins[30:25] << 5)
				| (ins[11:8] << 1);
			IMM_J: return ({32{ins[31]}} << 20) | (ins[19:12] << 12) | (ins[20] << 11)
				| (ins[30:21] << 1);
			IMM_U: return {ins[31:12], 12'b0};
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] forwarded(input logic [4:0] idx);
		if (idx == 5'd0)
			return 32'd0;
		if ({1'b0, idx} == m_rd)
			return alu_result_ex;	// ex beats mem beats wb
		if ({1'b0, idx} == mem_rd)
			return mem_data;
		if (wb_valid && (idx == wb_rd))
			return wb_data;
		return model_regs[idx];
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] w;
		w = $urandom;
		w[11:7] = 5'($urandom % 8);	// small indices so hazards are frequent
		w[19:15] = 5'($urandom % 8);
		w[24:20] = 5'($urandom % 8);
		case ($urandom % 10)
			0: w[6:0] = `OP_LUI;
			1: w[6:0] = `OP_AUIPC;
			2: w[6:0] = `OP_JAL;
			3:
			begin
				w[6:0] = `OP_JALR;
				if (($urandom % 8) != 0)
					w[14:12] = 3'b000;
			end
			4: w[6:0] = `OP_BRANCH;
			5: w[6:0] = `OP_LOAD;
			6:
			begin
				w[6:0] = `OP_STORE;
				w[14:12] = 3'($urandom % 4);
			end
			7:
			begin
				w[6:0] = `OP_ALU_IR;
				if (($urandom % 8) != 0)
					w[31:25] = ($urandom % 2) ? `FUNCT7_ALT : `FUNCT7_BASE;
			end
			8:
			begin
				w[6:0] = `OP_ALU_RR;
				case ($urandom % 7)
					0, 1: w[31:25] = `FUNCT7_ALT;
					2, 3: w[31:25] = `FUNCT7_MULDIV;
					4: w[31:25] = 7'($urandom);	// mostly illegal funct7
					default: w[31:25] = `FUNCT7_BASE;
				endcase
			end
			default: w[6:0] = 7'($urandom);	// mostly undefined opcodes
		endcase
		return w;
	endfunction

	task automatic decode_ref(input logic [31:0] ins, input logic vld);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = ins[14:12];
		f7 = ins[31:25];
		d_alu = ALU_NONE;
		d_br = BR_NONE;
		d_size = MEM_B;
		d_fmt = IMM_NONE;
		d_load = 1'b0;
		d_store = 1'b0;
		d_uns = 1'b0;
		d_jal = 1'b0;
		d_jalr = 1'b0;
		d_only2 = 1'b0;
		d_wr = 1'b0;
		d_s1sel = S1_REG;
		d_s2sel = S2_ZERO;
		if (vld)
		begin
			case (ins[6:0])
				`OP_LUI:
				begin
					d_fmt = IMM_U;
					d_s1sel = S1_ZERO;
					d_s2sel = S2_IMM;
					d_only2 = 1'b1;
				end
				`OP_AUIPC:
				begin
					d_alu = ALU_ADD;
					d_fmt = IMM_U;
					d_s1sel = S1_PC;
					d_s2sel = S2_IMM;
				end
				`OP_JAL:
				begin
					d_jal = 1'b1;
					d_fmt = IMM_J;
					d_s1sel = S1_ZERO;
					d_s2sel = S2_LINK;
					d_only2 = 1'b1;
				end
				`OP_JALR:
				begin
					d_jalr = (f3 == 3'b000);
					d_fmt = d_jalr ? IMM_I : IMM_NONE;
					d_s2sel = d_jalr ? S2_LINK : S2_ZERO;
					d_only2 = d_jalr;
				end
				`OP_BRANCH:
				begin
					case (f3)
						`F3_BEQ:  d_br = BEQ;
						`F3_BNE:  d_br = BNE;
						`F3_BLT:  d_br = BLT;
						`F3_BGE:  d_br = BGE;
						`F3_BLTU: d_br = BLTU;
						`F3_BGEU: d_br = BGEU;
						default:  d_br = BR_NONE;
					endcase
					case (f3)
						`F3_BEQ, `F3_BNE:   d_alu = ALU_SUB;
						`F3_BLT, `F3_BGE:   d_alu = ALU_SLT;
						`F3_BLTU, `F3_BGEU: d_alu = ALU_SLTU;
						default:            d_alu = ALU_NONE;
					endcase
				end
				`OP_LOAD:
				begin
					d_load = (f3 != 3'd3) && (f3 < 3'd6);
					d_uns = d_load && f3[2];
				end
				`OP_STORE:
				begin
					d_store = (f3 < 3'd3);
				end
				`OP_ALU_IR:
				begin
					d_alu = alu_from_f3(f3, 1'b0);
					if ((f3 == `F3_SLL) && (f7 != `FUNCT7_BASE))
						d_alu = ALU_NONE;
					if (f3 == `F3_SRL)
						d_alu = (f7 == `FUNCT7_BASE) ? ALU_SRL :
							(f7 == `FUNCT7_ALT) ? ALU_SRA : ALU_NONE;
					d_fmt = (d_alu != ALU_NONE) ? IMM_I : IMM_NONE;
					d_s2sel = (d_alu != ALU_NONE) ? S2_IMM : S2_ZERO;
				end
				`OP_ALU_RR:
				begin
					if (f7 == `FUNCT7_BASE || f7 == `FUNCT7_MULDIV)
						d_alu = alu_from_f3(f3, f7 == `FUNCT7_MULDIV);
					else if (f7 == `FUNCT7_ALT && f3 == `F3_ADD)
						d_alu = ALU_SUB;
					else if (f7 == `FUNCT7_ALT && f3 == `F3_SRL)
						d_alu = ALU_SRA;
				end
				default:
					d_alu = ALU_NONE;
			endcase
			if (d_load || d_store)
			begin
				d_alu = ALU_ADD;	// address add
				d_fmt = d_load ? IMM_I : IMM_S;
				d_s2sel = S2_IMM;
				d_size = (f3[1:0] == 2'd0) ? MEM_B : (f3[1:0] == 2'd1) ? MEM_H : MEM_W;
			end
			if (ins[6:0] == `OP_BRANCH || ins[6:0] == `OP_ALU_RR)
				d_s2sel = (d_alu != ALU_NONE) ? S2_REG : S2_ZERO;
			if (d_br != BR_NONE)
				d_fmt = IMM_B;
			d_wr = (ins[6:0] inside {`OP_LUI, `OP_AUIPC, `OP_JAL}) || d_jalr || d_load
				|| ((ins[6:0] inside {`OP_ALU_IR, `OP_ALU_RR}) && d_alu != ALU_NONE);
		end
	endtask

	task automatic idle_model(input logic clear_pc);
		m_valid = 1'b0;
		m_alu = ALU_NONE;
		m_br = BR_NONE;
		m_load = 1'b0;
		m_store = 1'b0;
		m_size = MEM_B;
		m_uns = 1'b0;
		m_jalr = 1'b0;
		m_only2 = 1'b0;
		m_src1 = '0;
		m_src2 = '0;
		m_sdata = '0;
		m_imm = '0;
		m_rd = `NO_RD;
		if (clear_pc)
			m_pc = '0;
	endtask

	// next register contents as the coming rising edge loads them
	task automatic advance_model();
		logic [31:0] v1;
		logic [31:0] v2;
		v1 = forwarded(instr[19:15]);
		v2 = forwarded(instr[24:20]);
		if (ex_ready && (redirect_ex || m_jalr))
			idle_model(1'b0);	// flush keeps pc_ex
		else if (ex_ready)
		begin
			m_valid = if_valid;
			m_alu = d_alu;
			m_br = d_br;
			m_load = d_load;
			m_store = d_store;
			m_size = d_size;
			m_uns = d_uns;
			m_jalr = d_jalr;
			m_only2 = d_only2;
			m_src1 = (d_s1sel == S1_PC) ? pc : (d_s1sel == S1_ZERO) ? 32'd0 : v1;
			case (d_s2sel)
				S2_LINK: m_src2 = pc + 32'd4;
				S2_IMM:  m_src2 = imm_value(d_fmt, instr);
				S2_REG:  m_src2 = v2;
				default: m_src2 = 32'd0;
			endcase
			m_sdata = v2;
			m_imm = imm_value(d_fmt, instr);
			m_rd = d_wr ? {1'b0, instr[11:7]} : `NO_RD;
			m_pc = pc;
		end
		if (wb_valid && (wb_rd != 5'd0))
			model_regs[wb_rd] = wb_data;
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		compare_field("dec_ready", dec_ready, ex_ready);
		compare_field("jal_dec", jal_dec, d_jal);
		compare_field("imm_dec", imm_dec, imm_value(d_fmt, instr));
		compare_field("dec_valid", dec_valid, m_valid);
		compare_field("alu_op_ex", alu_op_ex, m_alu);
		compare_field("br_op_ex", br_op_ex, m_br);
		compare_field("load_ex", load_ex, m_load);
		compare_field("store_ex", store_ex, m_store);
		compare_field("mem_size_ex", mem_size_ex, m_size);
		compare_field("mem_unsigned_ex", mem_unsigned_ex, m_uns);
		compare_field("jalr_ex", jalr_ex, m_jalr);
		compare_field("only_src2_ex", only_src2_ex, m_only2);
		compare_field("src1_ex", src1_ex, m_src1);
		compare_field("src2_ex", src2_ex, m_src2);
		compare_field("store_data_ex", store_data_ex, m_sdata);
		compare_field("imm_ex", imm_ex, m_imm);
		compare_field("rd_ex", rd_ex, m_rd);
		compare_field("pc_ex", pc_ex, m_pc);
	endtask

	task automatic drive_inputs();
		if (!(if_valid && !ex_ready))	// fetch holds an offered instruction not yet taken
		begin
			if_valid <= ($urandom % 10) < 8;
			instr <= random_instr();
			pc <= $urandom & 32'hffff_fffc;
		end
		ex_ready <= ($urandom % 4) != 0;
		redirect_ex <= ($urandom % 20) == 0;
		alu_result_ex <= $urandom;
		mem_rd <= (($urandom % 4) == 0) ? `NO_RD : 6'($urandom % 8);
		mem_data <= $urandom;
		wb_valid <= 1'($urandom % 2);
		wb_rd <= 5'($urandom % 8);
		wb_data <= $urandom;
	endtask

	initial
	begin
		void'($urandom(3573));
		checks = 0;
		errors = 0;
		cpu_rstn = 1'b0;
		if_valid = 1'b0;
		instr = '0;
		pc = '0;
		ex_ready = 1'b0;
		redirect_ex = 1'b0;
		alu_result_ex = '0;
		mem_rd = `NO_RD;
		mem_data = '0;
		wb_valid = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		idle_model(1'b1);
		repeat (2) @(posedge cpu_clk);
		@(negedge cpu_clk);
		decode_ref(instr, if_valid);
		check_outputs();	// values held in reset
		@(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
		begin
			drive_inputs();
			@(negedge cpu_clk);
			decode_ref(instr, if_valid);
			check_outputs();
			advance_model();
			@(posedge cpu_clk);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(2 * (NUM_CYCLES + 3) * CLK_PERIOD);
		$display("watchdog: the run did not finish in time, it looks hung");
		$display("TESTS FAILED");
		$finish;
	end

endmodule
